// ==== common/eth_settings.svh ====
`ifndef ETH_SETTINGS_SVH
`define ETH_SETTINGS_SVH

// fifo sizing, same depth for all three fifos
`define FIFO_DEPTH_LOG2     9

////////////////////////////////////////////////////////////
// ethernet / arp constants
////////////////////////////////////////////////////////////
`define ETH_BROADCAST_HI    32'hFFFF_FFFF
`define ETHTYPE_ARP_HTYPE   32'h0806_0001   // ethertype arp + htype ethernet
`define ARP_PTYPE_SIZES     32'h0800_0604   // ptype ipv4, hlen 6, plen 4
`define ARP_OP_REQUEST      16'h0001
`define ARP_OP_REPLY        16'h0002

////////////////////////////////////////////////////////////
// ipv4 / udp constants
////////////////////////////////////////////////////////////
`define ETHTYPE_IPV4_VER    32'h0800_4500   // ethertype ipv4 + version/ihl/tos
`define IP_FLAGS_WORD       32'h4000_FF11   // df, ttl 255, proto udp
`define IP_LEN_OVERHEAD     16'd30
`define UDP_LEN_OVERHEAD    16'd10

// word counts per frame
`define HDR_WORDS           11
`define ARP_WORDS           11
`define ARP_MIN_WORDS       11

`endif

// ==== common/stream_pkg.sv ====
`default_nettype none

`include "eth_settings.svh"

package stream_pkg;

    typedef logic [31:0] data_word_t;
    typedef logic [3:0] hdr_index_t;                    // header word counter
    typedef logic [`FIFO_DEPTH_LOG2:0] fifo_level_t;    // one extra bit for full
    typedef logic [15:0] byte_len_t;

endpackage

`default_nettype wire

// ==== common/net_pkg.sv ====
`default_nettype none

package net_pkg;

    // addresses and ports
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // one received word split into its two 16-bit fields
    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } net_halves_t;

    // received word, read whole or by halves
    typedef union packed {
        logic [31:0] word;
        net_halves_t halves;
    } net_word_u;

endpackage

`default_nettype wire

// ==== common/word_stream_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface word_stream_if;
    import stream_pkg::*;

    data_word_t data;
    logic valid;
    logic ready;
    logic last;    // marks final word of a frame

    modport source (output data, output valid, output last, input ready);
    modport sink (input data, input valid, input last, output ready);

endinterface

`default_nettype wire

// ==== rtl/stream_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "eth_settings.svh"

module stream_fifo (
    input wire clk,
    input wire reset,
    word_stream_if.sink in_s,
    word_stream_if.source out_s,
    output stream_pkg::fifo_level_t level,
    output stream_pkg::fifo_level_t packets
);
    import stream_pkg::*;

    localparam int DEPTH = 1 << `FIFO_DEPTH_LOG2;

    typedef logic [`FIFO_DEPTH_LOG2-1:0] ptr_t;

    data_word_t mem_data [DEPTH];
    logic mem_last [DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    logic wr_en;
    logic rd_en;

    assign in_s.ready = (level != fifo_level_t'(DEPTH));   // low only when full
    assign out_s.valid = (level != '0);
    assign out_s.data = mem_data[rd_ptr];
    assign out_s.last = mem_last[rd_ptr];

    assign wr_en = in_s.valid && in_s.ready;
    assign rd_en = out_s.valid && out_s.ready;

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= in_s.data;
            mem_last[wr_ptr] <= in_s.last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level <= '0;
            packets <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            level <= level + fifo_level_t'(wr_en) - fifo_level_t'(rd_en);
            // whole frames held, counted by their last words
            packets <= packets + fifo_level_t'(wr_en && in_s.last)
                               - fifo_level_t'(rd_en && out_s.last);
        end
    end

endmodule

`default_nettype wire

// ==== arp/arp_responder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "eth_settings.svh"

module arp_responder (
    input wire clk,
    input wire reset,
    word_stream_if.sink rx,
    word_stream_if.source reply,
    input wire net_pkg::mac_addr_t own_mac,
    input wire net_pkg::ip_addr_t own_ip
);
    import net_pkg::*;
    import stream_pkg::*;

    localparam data_word_t BCAST = `ETH_BROADCAST_HI;
    localparam data_word_t PTYPE_SIZES = `ARP_PTYPE_SIZES;
    localparam hdr_index_t CHECK_LAST = hdr_index_t'(`ARP_MIN_WORDS - 1);
    localparam hdr_index_t REPLY_LAST = hdr_index_t'(`ARP_WORDS - 1);

    net_word_u rx_word;
    hdr_index_t rx_idx;
    hdr_index_t tx_idx;
    logic word_ok;
    logic bad;          // mismatch seen, drop till last
    logic checked;      // all request words seen
    logic bad_now;
    logic checked_now;
    logic pending;
    logic rx_fire;
    logic tx_fire;
    mac_addr_t req_mac;
    ip_addr_t req_ip;

    assign rx_word = rx.data;
    assign rx.ready = !pending;     // requests queue upstream meanwhile
    assign rx_fire = rx.valid && rx.ready;
    assign tx_fire = reply.valid && reply.ready;

    ////////////////////////////////////////////////////////////
    // request parsing
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (rx_idx)
            4'd0: word_ok = (rx_word.word == BCAST) || (rx_word.word == own_mac[47:16]);
            4'd1: word_ok = (rx_word.halves.hi == BCAST[15:0]) ||
                            (rx_word.halves.hi == own_mac[15:0]);
            4'd3: word_ok = (rx_word.word == `ETHTYPE_ARP_HTYPE);
            4'd4: word_ok = (rx_word.halves.hi == PTYPE_SIZES[31:16]);
            4'd5: word_ok = (rx_word.halves.hi == `ARP_OP_REQUEST);
            4'd9: word_ok = (rx_word.halves.lo == own_ip[31:16]);     // target ip
            4'd10: word_ok = (rx_word.halves.hi == own_ip[15:0]);
            default: word_ok = 1'b1;
        endcase
    end

    assign bad_now = bad || !word_ok;
    assign checked_now = checked || (rx_idx == CHECK_LAST);

    // requester fields
    always_ff @(posedge clk) begin
        if (rx_fire) begin
            case (rx_idx)
                4'd5: req_mac[47:32] <= rx_word.halves.lo;
                4'd6: req_mac[31:0] <= rx_word.word;
                4'd7: req_ip <= rx_word.word;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_idx <= '0;
            tx_idx <= '0;
            bad <= 1'b0;
            checked <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (rx_fire) begin
                if (rx.last) begin
                    rx_idx <= '0;
                    bad <= 1'b0;
                    checked <= 1'b0;
                    pending <= !bad_now && checked_now;
                end else begin
                    if (rx_idx <= CHECK_LAST)
                        rx_idx <= rx_idx + 1'b1;    // saturates past the request
                    bad <= bad_now;
                    checked <= checked_now;
                end
            end
            if (tx_fire) begin
                if (reply.last) begin
                    tx_idx <= '0;
                    pending <= 1'b0;
                end else begin
                    tx_idx <= tx_idx + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // reply words
    ////////////////////////////////////////////////////////////
    assign reply.valid = pending;
    assign reply.last = (tx_idx == REPLY_LAST);

    always_comb begin
        case (tx_idx)
            4'd0: reply.data = req_mac[47:16];
            4'd1: reply.data = {req_mac[15:0], own_mac[47:32]};
            4'd2: reply.data = own_mac[31:0];
            4'd3: reply.data = `ETHTYPE_ARP_HTYPE;
            4'd4: reply.data = PTYPE_SIZES;
            4'd5: reply.data = {`ARP_OP_REPLY, own_mac[47:32]};
            4'd6: reply.data = own_mac[31:0];                // sender mac lo
            4'd7: reply.data = own_ip;
            4'd8: reply.data = req_mac[47:16];
            4'd9: reply.data = {req_mac[15:0], req_ip[31:16]};
            default: reply.data = {req_ip[15:0], 16'h0000};
        endcase
    end

endmodule

`default_nettype wire

// ==== udp/ip_header_checksum.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "eth_settings.svh"

module ip_header_checksum (
    input wire clk,
    input wire reset,
    input wire stream_pkg::byte_len_t ip_len,
    input wire net_pkg::ip_addr_t src_ip,
    input wire net_pkg::ip_addr_t dst_ip,
    output logic [15:0] checksum
);
    localparam logic [31:0] IPV4_VER = `ETHTYPE_IPV4_VER;
    localparam logic [31:0] FLAGS = `IP_FLAGS_WORD;

    logic [31:0] sum_raw;
    logic [31:0] sum_fold;

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_raw <= '0;
            sum_fold <= '0;
            checksum <= '0;
        end else begin
            // all fixed and variable header halves, id is zero
            sum_raw <= 32'(IPV4_VER[15:0]) + 32'(ip_len) + 32'(FLAGS[31:16])
                     + 32'(FLAGS[15:0]) + 32'(src_ip[31:16]) + 32'(src_ip[15:0])
                     + 32'(dst_ip[31:16]) + 32'(dst_ip[15:0]);
            sum_fold <= 32'(sum_raw[31:16]) + 32'(sum_raw[15:0]);
            checksum <= ~(sum_fold[31:16] + sum_fold[15:0]);    // second fold
        end
    end

endmodule

`default_nettype wire

// ==== udp/udp_tx_framer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "eth_settings.svh"

module udp_tx_framer (
    input wire clk,
    input wire reset,
    word_stream_if.sink payload,
    word_stream_if.source frame,
    input wire stream_pkg::fifo_level_t packets_ready,
    input wire stream_pkg::byte_len_t payload_bytes,
    input wire net_pkg::mac_addr_t src_mac,
    input wire net_pkg::mac_addr_t dst_mac,
    input wire net_pkg::ip_addr_t src_ip,
    input wire net_pkg::ip_addr_t dst_ip,
    input wire net_pkg::udp_port_t src_port,
    input wire net_pkg::udp_port_t dst_port
);
    import net_pkg::*;
    import stream_pkg::*;

    localparam hdr_index_t HDR_LAST = hdr_index_t'(`HDR_WORDS - 1);

    mac_addr_t src_mac_q;
    mac_addr_t dst_mac_q;
    ip_addr_t src_ip_q;
    ip_addr_t dst_ip_q;
    udp_port_t src_port_q;
    udp_port_t dst_port_q;
    byte_len_t ip_len;
    byte_len_t udp_len;
    logic [15:0] checksum;
    hdr_index_t hdr_idx;
    logic busy;
    logic in_hdr;
    data_word_t hdr_word;

    // config snapshot
    always_ff @(posedge clk) begin
        src_mac_q <= src_mac;
        dst_mac_q <= dst_mac;
        src_ip_q <= src_ip;
        dst_ip_q <= dst_ip;
        src_port_q <= src_port;
        dst_port_q <= dst_port;
        ip_len <= payload_bytes + `IP_LEN_OVERHEAD;
        udp_len <= payload_bytes + `UDP_LEN_OVERHEAD;
    end

    ip_header_checksum u_checksum (
        .clk      (clk),
        .reset    (reset),
        .ip_len   (ip_len),
        .src_ip   (src_ip_q),
        .dst_ip   (dst_ip_q),
        .checksum (checksum)
    );

    ////////////////////////////////////////////////////////////
    // header sequencing
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (hdr_idx)
            4'd0: hdr_word = dst_mac_q[47:16];
            4'd1: hdr_word = {dst_mac_q[15:0], src_mac_q[47:32]};
            4'd2: hdr_word = src_mac_q[31:0];
            4'd3: hdr_word = `ETHTYPE_IPV4_VER;
            4'd4: hdr_word = {ip_len, 16'h0000};       // total length, id 0
            4'd5: hdr_word = `IP_FLAGS_WORD;
            4'd6: hdr_word = {checksum, src_ip_q[31:16]};
            4'd7: hdr_word = {src_ip_q[15:0], dst_ip_q[31:16]};
            4'd8: hdr_word = {dst_ip_q[15:0], src_port_q};
            4'd9: hdr_word = {dst_port_q, udp_len};
            default: hdr_word = '0;                     // rest of udp header
        endcase
    end

    assign in_hdr = (hdr_idx <= HDR_LAST);

    // header from registers, then payload passed straight through
    assign frame.valid = busy && (in_hdr || payload.valid);
    assign frame.data = in_hdr ? hdr_word : payload.data;
    assign frame.last = !in_hdr && payload.last;
    assign payload.ready = busy && !in_hdr && frame.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            hdr_idx <= '0;
        end else if (!busy) begin
            if (packets_ready != '0) begin      // one whole packet waiting
                busy <= 1'b1;
                hdr_idx <= '0;
            end
        end else if (in_hdr) begin
            if (frame.ready)
                hdr_idx <= hdr_idx + 1'b1;
        end else if (payload.valid && frame.ready && payload.last) begin
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/frame_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_arbiter (
    input wire clk,
    input wire reset,
    word_stream_if.sink arp_in,
    word_stream_if.sink udp_in,
    word_stream_if.source out_s
);
    logic grant_udp;    // held source while locked
    logic locked;
    logic sel_udp;

    // arp wins when free, otherwise keep the current frame's source
    assign sel_udp = locked ? grant_udp : (!arp_in.valid && udp_in.valid);

    assign out_s.data = sel_udp ? udp_in.data : arp_in.data;
    assign out_s.valid = sel_udp ? udp_in.valid : arp_in.valid;
    assign out_s.last = sel_udp ? udp_in.last : arp_in.last;
    assign arp_in.ready = !sel_udp && out_s.ready;
    assign udp_in.ready = sel_udp && out_s.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            locked <= 1'b0;
            grant_udp <= 1'b0;
        end else if (out_s.valid && out_s.ready && out_s.last) begin
            locked <= 1'b0;                 // frame done
        end else if (out_s.valid) begin
            locked <= 1'b1;                 // hold once a word is offered
            grant_udp <= sel_udp;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/udp_arp_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module udp_arp_engine (
    input wire clk,
    input wire reset,
    input wire stream_pkg::data_word_t rx_data,
    input wire rx_valid,
    input wire rx_last,
    output logic rx_ready,
    input wire stream_pkg::data_word_t pay_data,
    input wire pay_valid,
    input wire pay_last,
    output logic pay_ready,
    output stream_pkg::data_word_t out_data,
    output logic out_valid,
    output logic out_last,
    input wire out_ready,
    input wire stream_pkg::byte_len_t payload_bytes,
    input wire net_pkg::mac_addr_t src_mac,
    input wire net_pkg::ip_addr_t src_ip,
    input wire net_pkg::udp_port_t src_port,
    input wire net_pkg::mac_addr_t dst_mac,
    input wire net_pkg::ip_addr_t dst_ip,
    input wire net_pkg::udp_port_t dst_port
);
    import stream_pkg::*;

    fifo_level_t pay_packets;   // complete payload packets buffered

    word_stream_if rx_port_link ();
    word_stream_if pay_port_link ();
    word_stream_if out_port_link ();
    word_stream_if rx_link ();
    word_stream_if pay_link ();
    word_stream_if arp_link ();
    word_stream_if udp_link ();
    word_stream_if merged_link ();

    ////////////////////////////////////////////////////////////
    // top ports to streams
    ////////////////////////////////////////////////////////////
    assign rx_port_link.data = rx_data;
    assign rx_port_link.valid = rx_valid;
    assign rx_port_link.last = rx_last;
    assign rx_ready = rx_port_link.ready;

    assign pay_port_link.data = pay_data;
    assign pay_port_link.valid = pay_valid;
    assign pay_port_link.last = pay_last;
    assign pay_ready = pay_port_link.ready;

    assign out_data = out_port_link.data;
    assign out_valid = out_port_link.valid;
    assign out_last = out_port_link.last;
    assign out_port_link.ready = out_ready;

    stream_fifo rx_fifo (
        .clk(clk), .reset(reset), .in_s(rx_port_link), .out_s(rx_link),
        .level(), .packets()
    );

    stream_fifo pay_fifo (
        .clk(clk), .reset(reset), .in_s(pay_port_link), .out_s(pay_link),
        .level(), .packets(pay_packets)
    );

    arp_responder u_arp (
        .clk(clk), .reset(reset), .rx(rx_link), .reply(arp_link),
        .own_mac(src_mac), .own_ip(src_ip)
    );

    udp_tx_framer u_framer (
        .clk(clk), .reset(reset), .payload(pay_link), .frame(udp_link),
        .packets_ready(pay_packets), .payload_bytes(payload_bytes),
        .src_mac(src_mac), .dst_mac(dst_mac), .src_ip(src_ip), .dst_ip(dst_ip),
        .src_port(src_port), .dst_port(dst_port)
    );

    frame_arbiter u_arbiter (
        .clk(clk), .reset(reset), .arp_in(arp_link), .udp_in(udp_link),
        .out_s(merged_link)
    );

    stream_fifo out_fifo (
        .clk(clk), .reset(reset), .in_s(merged_link), .out_s(out_port_link),
        .level(), .packets()
    );

endmodule

`default_nettype wire

// ==== tests/tb_udp_arp_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_udp_arp_engine;

    localparam int TIMEOUT = 2000;      // cycles allowed per wait
    localparam int QUIET_CYCLES = 300;
    localparam int PAY_BYTES = 16;
    localparam logic [47:0] OWN_MAC = 48'h0A1B_2C3D_4E5F;
    localparam logic [31:0] OWN_IP = 32'hC0A8_0164;
    localparam logic [15:0] SRC_PORT = 16'h1F90;
    localparam logic [47:0] DST_MAC = 48'h0011_2233_4455;
    localparam logic [31:0] DST_IP = 32'hC0A8_010A;
    localparam logic [15:0] DST_PORT = 16'h2328;
    localparam logic [47:0] REQ_MAC = 48'h6677_8899_AABB;
    localparam logic [31:0] REQ_IP = 32'hC0A8_0105;
    localparam logic [31:0] OTHER_IP = 32'hC0A8_0177;

    logic clk;
    logic reset;
    logic [31:0] rx_data;
    logic rx_valid;
    logic rx_last;
    logic rx_ready;
    logic [31:0] pay_data;
    logic pay_valid;
    logic pay_last;
    logic pay_ready;
    logic [31:0] out_data;
    logic out_valid;
    logic out_last;
    logic out_ready;
    logic [15:0] payload_bytes;
    logic [47:0] src_mac;
    logic [31:0] src_ip;
    logic [15:0] src_port;
    logic [47:0] dst_mac;
    logic [31:0] dst_ip;
    logic [15:0] dst_port;

    logic [15:0] lfsr_state;
    logic [31:0] pay_q[$];     // payload words sent and not yet seen at the output
    logic [31:0] exp_q[$];
    logic [31:0] got_q[$];

    udp_arp_engine dut0 (
        .clk(clk), .reset(reset),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_last(rx_last), .rx_ready(rx_ready),
        .pay_data(pay_data), .pay_valid(pay_valid), .pay_last(pay_last),
        .pay_ready(pay_ready),
        .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
        .out_ready(out_ready),
        .payload_bytes(payload_bytes), .src_mac(src_mac), .src_ip(src_ip),
        .src_port(src_port), .dst_mac(dst_mac), .dst_ip(dst_ip), .dst_port(dst_port)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, expected);
            abort_run();
        end
    endtask

    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic random_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        int i;
        w = '0;
        for (i = 0; i < 32; i++)
            w = {w[30:0], random_bit()};
        return w;
    endfunction

    // one word on rx or payload input held until accepted
    task automatic push_word(input logic to_pay, input logic [31:0] word, input logic last);
        int waited;
        waited = 0;
        if (to_pay) begin
            pay_data <= word;
            pay_valid <= 1'b1;
            pay_last <= last;
        end else begin
            rx_data <= word;
            rx_valid <= 1'b1;
            rx_last <= last;
        end
        @(posedge clk);
        while (!(to_pay ? pay_ready : rx_ready)) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("input stream stalled, ready stayed low for %0d cycles", TIMEOUT);
                abort_run();
            end
            @(posedge clk);
        end
    endtask

    task automatic send_payload();
        logic [31:0] word;
        int i;
        for (i = 0; i < PAY_BYTES / 4; i++) begin
            word = random_word();
            pay_q.push_back(word);
            push_word(1'b1, word, i == PAY_BYTES / 4 - 1);
        end
        pay_valid <= 1'b0;
        pay_last <= 1'b0;
    endtask

    // broadcast arp request from REQ_MAC / REQ_IP
    task automatic send_rx_frame(input logic [15:0] op, input logic [31:0] target_ip);
        logic [31:0] words [11];
        int i;
        words[0] = 32'hFFFF_FFFF;
        words[1] = {16'hFFFF, REQ_MAC[47:32]};
        words[2] = REQ_MAC[31:0];
        words[3] = 32'h0806_0001;
        words[4] = 32'h0800_0604;
        words[5] = {op, REQ_MAC[47:32]};
        words[6] = REQ_MAC[31:0];
        words[7] = REQ_IP;
        words[8] = 32'h0;                   // target mac unknown
        words[9] = {16'h0000, target_ip[31:16]};
        words[10] = {target_ip[15:0], 16'h0000};
        for (i = 0; i < 11; i++)
            push_word(1'b0, words[i], i == 10);
        rx_valid <= 1'b0;
        rx_last <= 1'b0;
    endtask

    // collects one output frame with optional random out_ready stalls
    task automatic expect_frame(input logic stall);
        int waited;
        logic done;
        got_q.delete();
        waited = 0;
        done = 1'b0;
        while (!done) begin
            out_ready <= stall ? random_bit() : 1'b1;
            @(posedge clk);
            if (out_valid && out_ready) begin
                got_q.push_back(out_data);
                done = out_last;
                waited = 0;
            end else begin
                waited++;
                if (waited > TIMEOUT) begin
                    $display("no complete output frame arrived within %0d cycles", TIMEOUT);
                    abort_run();
                end
            end
        end
        out_ready <= 1'b0;
    endtask

    task automatic expect_no_output();
        int i;
        for (i = 0; i < QUIET_CYCLES; i++) begin
            @(posedge clk);
            if (out_valid) begin
                $display("an output frame appeared for a request that must be ignored");
                abort_run();
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [15:0] header_checksum(input logic [15:0] ip_len);
        logic [31:0] sum;
        sum = 32'h4500 + 32'(ip_len) + 32'h4000 + 32'hFF11
            + 32'(OWN_IP[31:16]) + 32'(OWN_IP[15:0])
            + 32'(DST_IP[31:16]) + 32'(DST_IP[15:0]);
        while (sum[31:16] != 16'h0)
            sum = 32'(sum[31:16]) + 32'(sum[15:0]);     // end-around carry
        return ~sum[15:0];
    endfunction

    task automatic build_udp_expect();
        logic [15:0] ip_len;
        logic [15:0] udp_len;
        int i;
        ip_len = 16'(PAY_BYTES + 30);
        udp_len = 16'(PAY_BYTES + 10);
        exp_q.push_back(DST_MAC[47:16]);
        exp_q.push_back({DST_MAC[15:0], OWN_MAC[47:32]});
        exp_q.push_back(OWN_MAC[31:0]);
        exp_q.push_back(32'h0800_4500);
        exp_q.push_back({ip_len, 16'h0000});
        exp_q.push_back(32'h4000_FF11);
        exp_q.push_back({header_checksum(ip_len), OWN_IP[31:16]});
        exp_q.push_back({OWN_IP[15:0], DST_IP[31:16]});
        exp_q.push_back({DST_IP[15:0], SRC_PORT});
        exp_q.push_back({DST_PORT, udp_len});
        exp_q.push_back(32'h0);
        for (i = 0; i < PAY_BYTES / 4; i++) begin
            if (pay_q.size() == 0) begin
                $display("a UDP frame came out with no payload packet outstanding");
                abort_run();
            end
            exp_q.push_back(pay_q.pop_front());
        end
    endtask

    task automatic build_arp_expect();
        exp_q.push_back(REQ_MAC[47:16]);
        exp_q.push_back({REQ_MAC[15:0], OWN_MAC[47:32]});
        exp_q.push_back(OWN_MAC[31:0]);
        exp_q.push_back(32'h0806_0001);
        exp_q.push_back(32'h0800_0604);
        exp_q.push_back({16'h0002, OWN_MAC[47:32]});
        exp_q.push_back(OWN_MAC[31:0]);
        exp_q.push_back(OWN_IP);
        exp_q.push_back(REQ_MAC[47:16]);
        exp_q.push_back({REQ_MAC[15:0], REQ_IP[31:16]});
        exp_q.push_back({REQ_IP[15:0], 16'h0000});
    endtask

    // length check also catches an early or missing out_last
    task automatic compare_frame(input string what);
        int i;
        check_value({"out_last position in ", what}, got_q.size(), exp_q.size());
        for (i = 0; i < got_q.size(); i++)
            check_value($sformatf("out_data %s word %0d", what, i), got_q[i], exp_q[i]);
        exp_q.delete();
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_reset_state();
        check_value("out_valid", out_valid, 1'b0);
        check_value("rx_ready", rx_ready, 1'b1);
        check_value("pay_ready", pay_ready, 1'b1);
    endtask

    task automatic test_udp_single();
        send_payload();
        build_udp_expect();
        expect_frame(1'b0);
        compare_frame("udp frame");
    endtask

    task automatic test_arp_reply();
        send_rx_frame(16'h0001, OWN_IP);
        build_arp_expect();
        expect_frame(1'b0);
        compare_frame("arp reply");
    endtask

    task automatic test_arp_rejects();
        send_rx_frame(16'h0001, OTHER_IP);
        send_rx_frame(16'h0002, OWN_IP);       // reply opcode instead of a request
        expect_no_output();
        test_arp_reply();
    endtask

    task automatic test_udp_stalled();
        send_payload();
        send_payload();
        expect_frame(1'b1);
        build_udp_expect();
        compare_frame("first stalled udp frame");
        expect_frame(1'b1);
        build_udp_expect();
        compare_frame("second stalled udp frame");
    endtask

    task automatic test_mixed_traffic();
        int arp_count;
        int udp_count;
        int i;
        arp_count = 0;
        udp_count = 0;
        send_payload();
        send_payload();
        send_rx_frame(16'h0001, OWN_IP);
        for (i = 0; i < 3; i++) begin
            expect_frame(1'b1);
            if (got_q.size() > 3 && got_q[3] == 32'h0806_0001) begin
                arp_count++;
                build_arp_expect();
            end else begin
                udp_count++;
                build_udp_expect();
            end
            compare_frame($sformatf("mixed frame %0d", i));
        end
        check_value("arp reply count", arp_count, 1);
        check_value("udp frame count", udp_count, 2);
    endtask

    initial begin
        lfsr_state = 16'd50842;
        reset = 1'b1;
        rx_data = '0;
        rx_valid = 1'b0;
        rx_last = 1'b0;
        pay_data = '0;
        pay_valid = 1'b0;
        pay_last = 1'b0;
        out_ready = 1'b0;
        payload_bytes = 16'(PAY_BYTES);
        src_mac = OWN_MAC;
        src_ip = OWN_IP;
        src_port = SRC_PORT;
        dst_mac = DST_MAC;
        dst_ip = DST_IP;
        dst_port = DST_PORT;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        repeat (5) @(posedge clk);      // config regs and checksum pipeline settle
        test_reset_state();
        test_udp_single();
        test_arp_reply();
        test_arp_rejects();
        test_udp_stalled();
        test_mixed_traffic();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
common/stream_pkg.sv
common/net_pkg.sv
common/word_stream_if.sv
rtl/stream_fifo.sv
arp/arp_responder.sv
udp/ip_header_checksum.sv
udp/udp_tx_framer.sv
rtl/frame_arbiter.sv
rtl/udp_arp_engine.sv
tests/tb_udp_arp_engine.sv

// ==== Bender.yml ====
package:
  name: udp_arp_engine

sources:
  - include_dirs:
      - common
    files:
      - common/stream_pkg.sv
      - common/net_pkg.sv
      - common/word_stream_if.sv
      - rtl/stream_fifo.sv
      - arp/arp_responder.sv
      - udp/ip_header_checksum.sv
      - udp/udp_tx_framer.sv
      - rtl/frame_arbiter.sv
      - rtl/udp_arp_engine.sv
  - target: simulation
    files:
      - tests/tb_udp_arp_engine.sv
